// File: build.f
+incdir+source
source/rob_pkg.sv
source/rob_alloc_if.sv
source/rob_ptr_counter.sv
source/rob_entry_store.sv
source/rob_commit_fsm.sv
source/rob_top.sv
tests/rob_props.sv
tests/rob_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := rob_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG) || ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/rob_tb.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module rob_tb import rob_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DEPTH        = `ROB_DEPTH;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_CYCLES  = 400;                    // Generous budget per test
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD;

    logic      clk = 1'b0;
    logic      rst;
    logic      dispatch_valid;
    rob_reg_t  dispatch_dest;
    logic      dispatch_reg_write;
    rob_data_t dispatch_pc;
    logic      dispatch_ready;
    rob_tag_t  dispatch_tag;
    logic      alu_done;
    logic      mul_done;
    logic      load_done;
    rob_tag_t  alu_tag;
    rob_tag_t  mul_tag;
    rob_tag_t  load_tag;
    rob_data_t alu_value;
    rob_data_t mul_value;
    rob_data_t load_value;
    logic      mispredict_valid;
    rob_tag_t  mispredict_tag;
    rob_data_t mispredict_pc;
    logic      flush;
    logic      commit_ready;
    logic      commit_valid;
    rob_data_t commit_value;
    rob_reg_t  commit_dest;
    logic      commit_reg_write;

    rob_data_t   exp_value [DEPTH];                       // Reference result per tag
    rob_reg_t    exp_dest  [DEPTH];
    logic        exp_rw    [DEPTH];
    rob_tag_t    order[$];                                // Live tags in program order
    rob_tag_t    pend[$];                                 // Tags still waiting for a result
    rob_tag_t    model_tail;                              // Next tag the model expects
    logic [15:0] lfsr_q = 16'd58;
    int unsigned seq;                                     // Dispatch sequence number
    int          errors;
    int          commits;
    int          dispatched;
    int          tests_run;

    rob_top rob_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic take_bits(input int n, output int unsigned v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | {31'b0, lfsr_q[15]};           // One step per bit
            lfsr_q = next_lfsr(lfsr_q);
        end
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    function automatic bit is_pending(input rob_tag_t tag);
        foreach (pend[i]) begin
            if (pend[i] == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic drop_pending(input rob_tag_t tag);
        int i;
        for (i = pend.size() - 1; i >= 0; i--) begin
            if (pend[i] == tag) pend.delete(i);
        end
    endtask

    task automatic init_inputs();
        rst                = 1'b1;
        dispatch_valid     = 1'b0;
        dispatch_dest      = '0;
        dispatch_reg_write = 1'b0;
        dispatch_pc        = '0;
        {alu_done, mul_done, load_done} = 3'b000;
        {alu_tag, mul_tag, load_tag}    = '0;
        {alu_value, mul_value, load_value} = '0;
        mispredict_valid   = 1'b0;
        mispredict_tag     = '0;
        mispredict_pc      = '0;
        flush              = 1'b0;
        commit_ready       = 1'b0;
    endtask

    task automatic clear_pulses();
        {alu_done, mul_done, load_done} = 3'b000;        // Completions last one cycle
        mispredict_valid = 1'b0;
        flush            = 1'b0;
    endtask

    // Up to one completion per unit from a random pending tag
    task automatic issue_completions();
        int unsigned r;
        int unsigned idx;
        int          unit;
        rob_tag_t    tag;
        for (unit = 0; unit < 3; unit++) begin
            take_bits(2, r);
            if (r != 0 && pend.size() > 0) begin
                take_bits(4, idx);
                idx = idx % pend.size();
                tag = pend[idx];
                pend.delete(idx);
                case (unit)
                    0: begin
                        {alu_done, alu_tag, alu_value} = {1'b1, tag, exp_value[tag]};
                    end
                    1: begin
                        {mul_done, mul_tag, mul_value} = {1'b1, tag, exp_value[tag]};
                    end
                    default: begin
                        {load_done, load_tag, load_value} = {1'b1, tag, exp_value[tag]};
                    end
                endcase
            end
        end
    endtask

    // Called 1 ns after the falling edge when outputs have settled
    task automatic sample_outputs();
        rob_tag_t tag;
        if (commit_valid && commit_ready) begin
            commits++;
            if (order.size() == 0) begin
                report_problem("commit seen while the model holds no live entry");
            end else begin
                tag = order.pop_front();
                assert (!is_pending(tag))
                    else report_fail($sformatf("tag %0d committed before its result", tag));
                assert (commit_value == exp_value[tag])
                    else report_fail($sformatf("tag %0d value %h, expected %h",
                                               tag, commit_value, exp_value[tag]));
                assert (commit_dest == exp_dest[tag] && commit_reg_write == exp_rw[tag])
                    else report_fail($sformatf("tag %0d dest %0d/%b, expected %0d/%b", tag,
                                               commit_dest, commit_reg_write,
                                               exp_dest[tag], exp_rw[tag]));
            end
        end
        if (dispatch_valid && dispatch_ready) begin   // Entry allocated at next edge
            assert (dispatch_tag == model_tail)
                else report_fail($sformatf("dispatch tag %0d, expected %0d",
                                           dispatch_tag, model_tail));
            exp_value[model_tail] = {8'hA5, seq[15:0], 4'h0, model_tail};
            exp_dest[model_tail]  = dispatch_dest;
            exp_rw[model_tail]    = dispatch_reg_write;
            order.push_back(model_tail);
            pend.push_back(model_tail);
            model_tail = model_tail + rob_tag_t'(1);
            seq++;
            dispatched++;
        end
    endtask

    // commit_mode 0 holds off, 1 always accepts, 2 random stalls
    task automatic run_cycle(input bit want_disp, input bit do_done, input int commit_mode);
        int unsigned r;
        @(negedge clk);
        clear_pulses();
        dispatch_valid = want_disp;
        take_bits(5, r);
        dispatch_dest = rob_reg_t'(r);
        take_bits(1, r);
        dispatch_reg_write = r[0];
        dispatch_pc = 32'h0000_1000 + {seq[29:0], 2'b00};
        if (do_done) issue_completions();
        take_bits(2, r);
        commit_ready = (commit_mode == 1) || (commit_mode == 2 && r != 0);  // 3 in 4
        #1;
        sample_outputs();
    endtask

    task automatic drain(input int commit_mode);
        while (order.size() > 0) begin
            run_cycle(1'b0, 1'b1, commit_mode);
        end
        repeat (2) begin
            run_cycle(1'b0, 1'b0, 1);                   // Any extra commit shows up here
        end
    endtask

    task automatic send_mispredict(input rob_tag_t br_tag, input rob_data_t target);
        @(negedge clk);
        clear_pulses();
        dispatch_valid   = 1'b0;
        commit_ready     = 1'b0;
        mispredict_valid = 1'b1;
        mispredict_tag   = br_tag;
        mispredict_pc    = target;
        #1;
        sample_outputs();
        while (order.size() > 0 && order[$] != br_tag) begin
            drop_pending(order.pop_back());             // Squashed entries the units drop
        end
        exp_value[br_tag] = target;                     // Branch result is its target
        model_tail = br_tag + rob_tag_t'(1);
    endtask

    task automatic send_flush();
        @(negedge clk);
        clear_pulses();
        dispatch_valid = 1'b0;
        commit_ready   = 1'b0;
        flush          = 1'b1;
        #1;
        sample_outputs();
        order.delete();
        pend.delete();
        model_tail = '0;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
    endtask

    initial begin
        int          err_mark;
        int          target;
        int          commit_mark;
        int          disp_mark;
        int unsigned r;
        rob_tag_t    br_tag;
        init_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        assert (!commit_valid && dispatch_ready && dispatch_tag == '0)
            else report_fail("outputs not idle after reset");

        err_mark = errors;                               // Fill until full, then hold
        while (order.size() < DEPTH) begin
            run_cycle(1'b1, 1'b0, 0);
        end
        repeat (4) begin
            run_cycle(1'b1, 1'b0, 0);
            assert (!dispatch_ready && order.size() == DEPTH)
                else report_fail("dispatch accepted while full");
        end
        drain(1);
        end_test("fill and wrap", err_mark);

        err_mark = errors;                               // Out-of-order completion
        repeat (40) begin
            take_bits(1, r);
            run_cycle(r[0], 1'b1, 1);
        end
        drain(1);
        end_test("random completion order", err_mark);

        err_mark    = errors;                            // Consumer back-pressure
        commit_mark = commits;
        disp_mark   = dispatched;
        repeat (60) begin
            take_bits(1, r);
            run_cycle(r[0], 1'b1, 2);
        end
        drain(2);
        assert (commits - commit_mark == dispatched - disp_mark)
            else report_problem("entries lost or duplicated under commit stalls");
        end_test("commit stalls", err_mark);

        err_mark = errors;                               // Branch mispredict
        target   = dispatched + 10;
        while (dispatched < target) begin
            run_cycle(1'b1, 1'b0, 0);
        end
        br_tag = order[3];
        drop_pending(br_tag);                            // Branch waits for resolution
        while (pend.size() > 0 || order[0] != br_tag) begin
            run_cycle(1'b0, 1'b1, 1);
        end
        send_mispredict(br_tag, 32'h0000_8000);
        target = dispatched + 4;
        while (dispatched < target) begin
            run_cycle(1'b1, 1'b1, 1);
        end
        drain(1);
        end_test("mispredict recovery", err_mark);

        err_mark = errors;                               // Full flush
        target   = dispatched + 6;
        while (dispatched < target) begin
            run_cycle(1'b1, 1'b1, 0);
        end
        send_flush();
        repeat (3) begin
            run_cycle(1'b0, 1'b0, 1);
            assert (!commit_valid && dispatch_ready && dispatch_tag == '0)
                else report_fail("buffer not empty after flush");
        end
        target = dispatched + 3;
        while (dispatched < target) begin
            run_cycle(1'b1, 1'b1, 1);
        end
        drain(1);
        end_test("flush", err_mark);

        $display("Summary: %0d tests, %0d commits checked, %0d errors",
                 tests_run, commits, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: tests/rob_props.sv
`timescale 1ns/100ps

module rob_props import rob_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      dispatch_valid,
    input rob_tag_t  dispatch_tag,      // Current tail
    input logic      full,              // Internal full flag
    input logic      mispredict_valid,
    input logic      flush,
    input logic      commit_valid,
    input logic      commit_ready,
    input rob_data_t commit_value,
    input rob_reg_t  commit_dest,
    input logic      commit_reg_write
);

    // Stalled head keeps its payload until taken
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && !commit_ready && !flush && !mispredict_valid) |=>
            (commit_valid && $stable(commit_value) && $stable(commit_dest)
             && $stable(commit_reg_write)))
        else $error("commit outputs changed while stalled");

    // Tail holds when a dispatch meets a full buffer
    no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        (full && dispatch_valid && !flush && !mispredict_valid) |=> $stable(dispatch_tag))
        else $error("allocation while the buffer is full");

    reset_idle: assert property (@(posedge clk)
        rst |=> !commit_valid)
        else $error("commit_valid high after reset");

endmodule

bind rob_top rob_props props_inst (
    .clk              (clk),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_tag     (dispatch_tag),
    .full             (full),
    .mispredict_valid (mispredict_valid),
    .flush            (flush),
    .commit_valid     (commit_valid),
    .commit_ready     (commit_ready),
    .commit_value     (commit_value),
    .commit_dest      (commit_dest),
    .commit_reg_write (commit_reg_write)
);

// File: source/rob_top.sv
`timescale 1ns/100ps

module rob_top import rob_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Dispatch
    input  logic      dispatch_valid,
    input  rob_reg_t  dispatch_dest,
    input  logic      dispatch_reg_write,
    input  rob_data_t dispatch_pc,
    output logic      dispatch_ready,
    output rob_tag_t  dispatch_tag,      // Tag the next accepted entry gets
    // Completions
    input  logic      alu_done,
    input  rob_tag_t  alu_tag,
    input  rob_data_t alu_value,
    input  logic      mul_done,
    input  rob_tag_t  mul_tag,
    input  rob_data_t mul_value,
    input  logic      load_done,
    input  rob_tag_t  load_tag,
    input  rob_data_t load_value,
    // Mispredict and flush
    input  logic      mispredict_valid,
    input  rob_tag_t  mispredict_tag,
    input  rob_data_t mispredict_pc,     // Branch target
    input  logic      flush,
    // Commit
    input  logic      commit_ready,
    output logic      commit_valid,
    output rob_data_t commit_value,
    output rob_reg_t  commit_dest,
    output logic      commit_reg_write
);

    rob_alloc_if rob_bus ();

    logic       alloc_en;
    logic       retire_en;
    logic       recovering;
    logic       full;
    logic       empty;
    logic       head_ready;
    rob_tag_t   head_tag;
    rob_tag_t   tail_tag;

    // No dispatch while full, recovering or redirecting
    assign dispatch_ready = !full && !recovering && !mispredict_valid && !flush;
    assign alloc_en       = dispatch_valid && dispatch_ready;
    assign dispatch_tag   = tail_tag;

    assign rob_bus.alloc_en        = alloc_en;
    assign rob_bus.alloc_tag       = tail_tag;
    assign rob_bus.alloc_dest      = dispatch_dest;
    assign rob_bus.alloc_reg_write = dispatch_reg_write;
    assign rob_bus.alloc_pc        = dispatch_pc;
    assign rob_bus.alu_done        = alu_done;
    assign rob_bus.alu_tag         = alu_tag;
    assign rob_bus.alu_value       = alu_value;
    assign rob_bus.mul_done        = mul_done;
    assign rob_bus.mul_tag         = mul_tag;
    assign rob_bus.mul_value       = mul_value;
    assign rob_bus.load_done       = load_done;
    assign rob_bus.load_tag        = load_tag;
    assign rob_bus.load_value      = load_value;
    assign rob_bus.redirect_en     = mispredict_valid;
    assign rob_bus.redirect_tag    = mispredict_tag;
    assign rob_bus.redirect_pc     = mispredict_pc;

    rob_ptr_counter ptr_inst (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .retire_en    (retire_en),
        .redirect_en  (mispredict_valid),
        .redirect_tag (mispredict_tag),
        .flush        (flush),
        .head_tag     (head_tag),
        .tail_tag     (tail_tag),
        .count        (),
        .full         (full),
        .empty        (empty)
    );

    rob_entry_store store_inst (
        .clk            (clk),
        .rst            (rst),
        .port           (rob_bus.store),
        .head_tag       (head_tag),
        .head_ready     (head_ready),
        .head_value     (commit_value),
        .head_dest      (commit_dest),
        .head_reg_write (commit_reg_write)
    );

    rob_commit_fsm fsm_inst (
        .clk              (clk),
        .rst              (rst),
        .empty            (empty),
        .head_ready       (head_ready),
        .commit_ready     (commit_ready),
        .mispredict_valid (mispredict_valid),
        .flush            (flush),
        .commit_valid     (commit_valid),
        .retire_en        (retire_en),
        .recovering       (recovering)
    );

endmodule

// File: source/rob_commit_fsm.sv
`timescale 1ns/100ps

module rob_commit_fsm import rob_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic empty,             // No live entries
    input  logic head_ready,        // Head has its result
    input  logic commit_ready,      // Consumer accepts
    input  logic mispredict_valid,  // Branch resolved wrong
    input  logic flush,
    output logic commit_valid,
    output logic retire_en,         // Head advance to counter
    output logic recovering         // Blocks dispatch
);

    commit_state_t state_q;
    commit_state_t state_next;

    always_comb begin
        state_next = state_q;
        case (state_q)
            ST_RUN: begin
                if (mispredict_valid) begin
                    state_next = ST_RECOVER;
                end
            end
            ST_RECOVER: begin
                state_next = ST_RUN;        // Exactly one cycle
            end
            default: begin
                state_next = ST_RUN;
            end
        endcase
        if (flush) begin
            state_next = ST_RUN;            // Flush wins over mispredict
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_next;
        end
    end

    // Retirement only in ST_RUN with a completed head
    assign commit_valid = (state_q == ST_RUN) && !empty && head_ready;
    assign retire_en    = commit_valid && commit_ready;  // Handshake edge
    assign recovering   = (state_q == ST_RECOVER);

endmodule

// File: source/rob_entry_store.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module rob_entry_store import rob_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    rob_alloc_if.store    port,            // Allocation, completion, redirect
    input  rob_tag_t      head_tag,        // From the pointer counter
    output logic          head_ready,      // Head result present
    output rob_data_t     head_value,
    output rob_reg_t      head_dest,
    output logic          head_reg_write
);

    logic [`ROB_DEPTH-1:0] ready_q;                 // Result arrived per entry
    logic [`ROB_DEPTH-1:0] reg_write_mem;           // Entry writes a register
    rob_data_t             value_mem [`ROB_DEPTH];  // PC at dispatch, then result
    rob_reg_t              dest_mem  [`ROB_DEPTH];

    // Ready bits where later writes in the block win
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= '0;
        end else begin
            if (port.alloc_en) begin
                ready_q[port.alloc_tag] <= 1'b0;    // Fresh entry waits for result
            end
            if (port.alu_done) begin
                ready_q[port.alu_tag] <= 1'b1;
            end
            if (port.mul_done) begin
                ready_q[port.mul_tag] <= 1'b1;
            end
            if (port.load_done) begin
                ready_q[port.load_tag] <= 1'b1;
            end
            if (port.redirect_en) begin
                ready_q[port.redirect_tag] <= 1'b1; // Branch resolved
            end
        end
    end

    // Payload in the same write order as the ready bits
    always_ff @(posedge clk) begin
        if (port.alloc_en) begin
            value_mem[port.alloc_tag]     <= port.alloc_pc;   // PC held until result
            dest_mem[port.alloc_tag]      <= port.alloc_dest;
            reg_write_mem[port.alloc_tag] <= port.alloc_reg_write;
        end
        if (port.alu_done) begin
            value_mem[port.alu_tag] <= port.alu_value;
        end
        if (port.mul_done) begin
            value_mem[port.mul_tag] <= port.mul_value;
        end
        if (port.load_done) begin
            value_mem[port.load_tag] <= port.load_value;
        end
        if (port.redirect_en) begin
            value_mem[port.redirect_tag] <= port.redirect_pc; // Target is the result
        end
    end

    // Combinational head readout for commit
    assign head_ready     = ready_q[head_tag];
    assign head_value     = value_mem[head_tag];
    assign head_dest      = dest_mem[head_tag];
    assign head_reg_write = reg_write_mem[head_tag];

endmodule

// File: source/rob_ptr_counter.sv
`timescale 1ns/100ps
`include "rob_params.svh"

module rob_ptr_counter import rob_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       alloc_en,      // Tail advance
    input  logic       retire_en,     // Head advance
    input  logic       redirect_en,   // Cut back to entry after branch
    input  rob_tag_t   redirect_tag,  // Branch tag
    input  logic       flush,         // Empty the buffer
    output rob_tag_t   head_tag,      // Oldest entry
    output rob_tag_t   tail_tag,      // Next free entry
    output rob_count_t count,         // Live entries
    output logic       full,
    output logic       empty
);

    rob_tag_t   head_adv;     // Head after any retirement this cycle
    rob_tag_t   head_next;
    rob_tag_t   tail_next;
    rob_count_t count_next;

    always_comb begin
        head_adv   = head_tag + rob_tag_t'(retire_en);   // Wraps modulo depth
        head_next  = head_adv;
        tail_next  = tail_tag;
        count_next = count;
        if (flush) begin                                 // Beats everything
            head_next  = '0;
            tail_next  = '0;
            count_next = '0;
        end else if (redirect_en) begin
            tail_next  = redirect_tag + 1'b1;            // Entry after the branch
            // Branch stays live, so the span head..branch is inclusive
            count_next = rob_count_t'(rob_tag_t'(redirect_tag - head_adv)) + 1'b1;
        end else begin
            if (alloc_en) begin
                tail_next = tail_tag + 1'b1;
            end
            case ({alloc_en, retire_en})
                2'b10:   count_next = count + 1'b1;      // Allocate only
                2'b01:   count_next = count - 1'b1;      // Retire only
                default: count_next = count;             // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_tag <= '0;
            tail_tag <= '0;
            count    <= '0;
        end else begin
            head_tag <= head_next;
            tail_tag <= tail_next;
            count    <= count_next;
        end
    end

    assign full  = (count == rob_count_t'(`ROB_DEPTH));  // All entries live
    assign empty = (count == '0);

endmodule

// File: source/rob_alloc_if.sv
`timescale 1ns/100ps

interface rob_alloc_if import rob_pkg::*; ();

    logic      alloc_en;          // Entry written at tail this edge
    rob_tag_t  alloc_tag;         // Tail at allocation
    rob_reg_t  alloc_dest;
    logic      alloc_reg_write;
    rob_data_t alloc_pc;

    logic      alu_done;          // Single-cycle completion pulses
    rob_tag_t  alu_tag;
    rob_data_t alu_value;
    logic      mul_done;
    rob_tag_t  mul_tag;
    rob_data_t mul_value;
    logic      load_done;
    rob_tag_t  load_tag;
    rob_data_t load_value;

    logic      redirect_en;       // Mispredict writes branch target
    rob_tag_t  redirect_tag;
    rob_data_t redirect_pc;

    modport source (
        output alloc_en, alloc_tag, alloc_dest, alloc_reg_write, alloc_pc,
        output alu_done, alu_tag, alu_value, mul_done, mul_tag, mul_value,
        output load_done, load_tag, load_value,
        output redirect_en, redirect_tag, redirect_pc
    );

    modport store (
        input alloc_en, alloc_tag, alloc_dest, alloc_reg_write, alloc_pc,
        input alu_done, alu_tag, alu_value, mul_done, mul_tag, mul_value,
        input load_done, load_tag, load_value,
        input redirect_en, redirect_tag, redirect_pc
    );

endinterface

// File: source/rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0]  rob_tag_t;    // Entry tag handed out at dispatch
    typedef logic [`ROB_DATA_W-1:0] rob_data_t;   // Result word or PC
    typedef logic [`ROB_REG_W-1:0]  rob_reg_t;    // Destination register index
    typedef logic [`ROB_TAG_W:0]    rob_count_t;  // Occupancy one bit wider than a tag

    // Retirement sequencer states
    typedef enum logic {
        ST_RUN     = 1'b0,   // Normal dispatch and retirement
        ST_RECOVER = 1'b1    // Single cycle after a mispredict
    } commit_state_t;

endpackage

// File: source/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

`define ROB_TAG_W  4                   // Tag bits that set the buffer depth
`define ROB_DEPTH  (1 << `ROB_TAG_W)   // Entries in the circular buffer
`define ROB_DATA_W 32                  // Result and PC width
`define ROB_REG_W  5                   // Architectural register index

`endif
